/* Bender.yml */
package:
  name: rename_unit

sources:
  # Packages first, then leaf blocks, then the top level
  - common/rename_cfg_pkg.sv
  - common/rename_port_pkg.sv
  - logic/rob_tag_ring.sv
  - checkpoint/checkpoint_stack.sv
  - rename/map_table.sv
  - rename/rename_unit.sv
  - target: test
    files:
      - verif/rename_unit_assert.sv
      - verif/tb_rename_unit.sv

/* checkpoint/checkpoint_stack.sv */
`timescale 1ns/10ps

module checkpoint_stack (
    input  logic clk,
    input  logic reset,
    input  logic flush_i,
    input  rename_port_pkg::restore_t  [rename_cfg_pkg::LANES-1:0] push_i,
    input  rename_port_pkg::commit_t   [rename_cfg_pkg::LANES-1:0] commits_i,
    input  rename_port_pkg::resolve_t                              resolve_i,
    output rename_port_pkg::restore_t                              restore_o,
    output rename_cfg_pkg::ckpt_count_t                            free_slots_o
);

    // Snapshot storage, oldest at head
    rename_cfg_pkg::map_snapshot_t snap_q    [rename_cfg_pkg::CKPT_DEPTH];
    rename_cfg_pkg::ring_ptr_t     ptr_q     [rename_cfg_pkg::CKPT_DEPTH];
    rename_cfg_pkg::map_snapshot_t snap_next [rename_cfg_pkg::CKPT_DEPTH];
    rename_cfg_pkg::ring_ptr_t     ptr_next  [rename_cfg_pkg::CKPT_DEPTH];

    rename_cfg_pkg::ckpt_idx_t   head_q;
    rename_cfg_pkg::ckpt_idx_t   tail_q;
    rename_cfg_pkg::ckpt_count_t count_q;

    // Next free slot after this cycle's pushes
    rename_cfg_pkg::ckpt_idx_t   wr_idx;
    rename_cfg_pkg::ckpt_count_t n_push;

    rename_cfg_pkg::map_snapshot_t head_snap;

    logic pop;
    logic mispredict;

    // Resolve only counts against a live entry
    assign pop        = resolve_i.valid && (count_q != '0);
    assign mispredict = pop && resolve_i.mispredict;

    // ====================
    // Commit sync and push
    // ====================

    always_comb begin
        wr_idx = tail_q;
        n_push = '0;
        for (int e = 0; e < rename_cfg_pkg::CKPT_DEPTH; e++) begin
            snap_next[e] = snap_q[e];
            ptr_next[e]  = ptr_q[e];
            // Stored maps must follow retirement, or a restore would resurrect ROB names
            for (int c = 0; c < rename_cfg_pkg::LANES; c++) begin
                snap_next[e] = rename_cfg_pkg::revert_on_commit(
                    snap_next[e], commits_i[c].valid, commits_i[c].arch, commits_i[c].tag);
            end
        end
        // Pushes land in lane order; new ones already carry the commits
        for (int l = 0; l < rename_cfg_pkg::LANES; l++) begin
            if (push_i[l].valid) begin
                snap_next[wr_idx] = push_i[l].snapshot;
                ptr_next[wr_idx]  = push_i[l].alloc_ptr;
                wr_idx = wr_idx + 1'b1;
                n_push = n_push + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < rename_cfg_pkg::CKPT_DEPTH; e++) begin
            snap_q[e] <= snap_next[e];
            ptr_q[e]  <= ptr_next[e];
        end
    end

    // ====================
    // Restore
    // ====================

    // Head entry with this cycle's commits folded in
    always_comb begin
        head_snap = snap_q[head_q];
        for (int c = 0; c < rename_cfg_pkg::LANES; c++) begin
            head_snap = rename_cfg_pkg::revert_on_commit(
                head_snap, commits_i[c].valid, commits_i[c].arch, commits_i[c].tag);
        end
    end

    assign restore_o.valid     = mispredict;
    assign restore_o.snapshot  = head_snap;
    assign restore_o.alloc_ptr = ptr_q[head_q];

    assign free_slots_o = rename_cfg_pkg::ckpt_count_t'(rename_cfg_pkg::CKPT_DEPTH) - count_q;

    // Queue pointers
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i || mispredict) begin
            // Everything younger than the bad branch goes away
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + rename_cfg_pkg::ckpt_idx_t'(pop);
            tail_q  <= wr_idx;
            count_q <= count_q - rename_cfg_pkg::ckpt_count_t'(pop) + n_push;
        end
    end

endmodule

/* common/rename_cfg_pkg.sv */
package rename_cfg_pkg;

    // ====================
    // Sizes
    // ====================

    // Rename width, one request lane per decoded instruction
    localparam int LANES      = 3;
    localparam int ARCH_REGS  = 32;
    localparam int ROB_DEPTH  = 32;
    // Branch checkpoints in flight
    localparam int CKPT_DEPTH = 4;

    localparam int ARCH_W     = $clog2(ARCH_REGS);
    localparam int ROB_TAG_W  = $clog2(ROB_DEPTH);
    // Register file names below, ROB names above
    localparam int PHYS_W     = $clog2(ARCH_REGS + ROB_DEPTH);
    localparam int CKPT_W     = $clog2(CKPT_DEPTH);

    // ====================
    // Types
    // ====================

    typedef logic [ARCH_W-1:0]    arch_reg_t;
    // Top bit set means the value lives in a ROB entry
    typedef logic [PHYS_W-1:0]    phys_reg_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;
    // ROB tag plus wrap bit
    typedef logic [ROB_TAG_W:0]   ring_ptr_t;
    // Holds 0 to ROB_DEPTH
    typedef logic [ROB_TAG_W:0]   rob_count_t;
    typedef logic [$clog2(LANES+1)-1:0] lane_cnt_t;
    typedef logic [CKPT_W-1:0]    ckpt_idx_t;
    typedef logic [CKPT_W:0]      ckpt_count_t;

    // Whole map, one physical name per architectural register
    typedef phys_reg_t [ARCH_REGS-1:0] map_snapshot_t;

    // Retire one commit into a map
    // Only reverts if the register still names the committing tag
    function automatic map_snapshot_t revert_on_commit(
        map_snapshot_t snap,
        logic          valid,
        arch_reg_t     arch,
        rob_tag_t      tag
    );
        map_snapshot_t res;
        res = snap;
        if (valid && arch != '0 && snap[arch] == {1'b1, tag}) begin
            res[arch] = {1'b0, arch};
        end
        return res;
    endfunction

endpackage

/* common/rename_port_pkg.sv */
package rename_port_pkg;

    // ====================
    // Decode side
    // ====================

    // One decoded instruction as presented to rename
    typedef struct packed {
        logic                      valid;
        logic                      branch;
        // rd is only mapped when rd_we is set
        logic                      rd_we;
        rename_cfg_pkg::arch_reg_t rs1;
        rename_cfg_pkg::arch_reg_t rs2;
        rename_cfg_pkg::arch_reg_t rd;
    } lane_req_t;

    // Renamed instruction, valid low when the lane was refused
    typedef struct packed {
        logic                      valid;
        rename_cfg_pkg::phys_reg_t rs1_phys;
        rename_cfg_pkg::phys_reg_t rs2_phys;
        rename_cfg_pkg::phys_reg_t rd_phys;
        // Previous mapping of rd, freed when this instruction retires
        rename_cfg_pkg::phys_reg_t old_rd_phys;
    } lane_res_t;

    // ====================
    // ROB and branch side
    // ====================

    // Retiring instruction from the ROB
    typedef struct packed {
        logic                      valid;
        rename_cfg_pkg::arch_reg_t arch;
        rename_cfg_pkg::rob_tag_t  tag;
    } commit_t;

    // Oldest unresolved branch, in order, one per cycle
    typedef struct packed {
        logic valid;
        logic mispredict;
    } resolve_t;

    // Checkpoint record
    // Also carries the per-lane pushes from map to stack
    typedef struct packed {
        logic                          valid;
        rename_cfg_pkg::map_snapshot_t snapshot;
        rename_cfg_pkg::ring_ptr_t     alloc_ptr;
    } restore_t;

endpackage

/* compile.f */
common/rename_cfg_pkg.sv
common/rename_port_pkg.sv
logic/rob_tag_ring.sv
checkpoint/checkpoint_stack.sv
rename/map_table.sv
rename/rename_unit.sv
verif/rename_unit_assert.sv
verif/tb_rename_unit.sv

/* logic/rob_tag_ring.sv */
`timescale 1ns/10ps

module rob_tag_ring (
    input  logic clk,
    input  logic reset,
    input  logic flush_i,
    input  rename_cfg_pkg::lane_cnt_t                             alloc_count_i,
    input  rename_port_pkg::commit_t  [rename_cfg_pkg::LANES-1:0] commits_i,
    input  rename_port_pkg::restore_t                             restore_i,
    output rename_cfg_pkg::ring_ptr_t [rename_cfg_pkg::LANES-1:0] tags_o,
    output rename_cfg_pkg::rob_count_t                            free_count_o
);

    // Allocation runs ahead, release follows retirement
    rename_cfg_pkg::ring_ptr_t alloc_ptr_q;
    rename_cfg_pkg::ring_ptr_t rel_ptr_q;
    rename_cfg_pkg::ring_ptr_t rel_ptr_next;
    rename_cfg_pkg::lane_cnt_t n_commit;

    // Count retiring instructions this cycle
    always_comb begin
        n_commit = '0;
        for (int c = 0; c < rename_cfg_pkg::LANES; c++) begin
            if (commits_i[c].valid) begin
                n_commit = n_commit + 1'b1;
            end
        end
    end

    assign rel_ptr_next = rel_ptr_q + rename_cfg_pkg::ring_ptr_t'(n_commit);

    // Lane i takes the pointer plus i, wrap bit included
    for (genvar l = 0; l < rename_cfg_pkg::LANES; l++) begin : g_tag
        assign tags_o[l] = alloc_ptr_q + rename_cfg_pkg::ring_ptr_t'(l);
    end

    // Wrap bit makes full and empty distinct
    assign free_count_o = rename_cfg_pkg::rob_count_t'(rename_cfg_pkg::ROB_DEPTH)
                          - (alloc_ptr_q - rel_ptr_q);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            alloc_ptr_q <= '0;
            rel_ptr_q   <= '0;
        end else begin
            rel_ptr_q <= rel_ptr_next;
            if (flush_i) begin
                // Nothing left in flight
                alloc_ptr_q <= rel_ptr_next;
            end else if (restore_i.valid) begin
                // Back to one past the mispredicted branch
                alloc_ptr_q <= restore_i.alloc_ptr;
            end else begin
                alloc_ptr_q <= alloc_ptr_q + rename_cfg_pkg::ring_ptr_t'(alloc_count_i);
            end
        end
    end

endmodule

/* rename/map_table.sv */
`timescale 1ns/10ps

module map_table (
    input  logic clk,
    input  logic reset,
    input  logic flush_i,
    input  rename_port_pkg::lane_req_t [rename_cfg_pkg::LANES-1:0] lanes_i,
    input  rename_port_pkg::commit_t   [rename_cfg_pkg::LANES-1:0] commits_i,
    input  rename_cfg_pkg::ring_ptr_t  [rename_cfg_pkg::LANES-1:0] tags_i,
    input  rename_cfg_pkg::rob_count_t                             free_count_i,
    input  rename_cfg_pkg::ckpt_count_t                            free_slots_i,
    input  rename_port_pkg::restore_t                              restore_i,
    output rename_port_pkg::lane_res_t [rename_cfg_pkg::LANES-1:0] results_o,
    output rename_cfg_pkg::lane_cnt_t                              alloc_count_o,
    output rename_port_pkg::restore_t  [rename_cfg_pkg::LANES-1:0] push_o
);

    // Every register in its register file home
    function automatic rename_cfg_pkg::map_snapshot_t identity_map();
        rename_cfg_pkg::map_snapshot_t m;
        for (int r = 0; r < rename_cfg_pkg::ARCH_REGS; r++) begin
            m[r] = rename_cfg_pkg::phys_reg_t'(r);
        end
        return m;
    endfunction

    rename_cfg_pkg::map_snapshot_t map_q;
    rename_cfg_pkg::map_snapshot_t map_next;

    // Working copy, advanced lane by lane
    rename_cfg_pkg::map_snapshot_t cur;
    rename_cfg_pkg::phys_reg_t     rd_phys;

    logic [rename_cfg_pkg::LANES-1:0] accept;
    // Lower lanes all accepted
    logic                             chain_ok;
    // Branches seen in lanes 0..i
    rename_cfg_pkg::ckpt_count_t      n_branch;
    rename_cfg_pkg::lane_cnt_t        n_accept;

    // ====================
    // Rename, combinational
    // ====================

    always_comb begin
        cur      = map_q;
        chain_ok = 1'b1;
        n_branch = '0;
        n_accept = '0;
        rd_phys  = '0;

        // Same-cycle commits go in first
        for (int c = 0; c < rename_cfg_pkg::LANES; c++) begin
            cur = rename_cfg_pkg::revert_on_commit(cur, commits_i[c].valid,
                                                   commits_i[c].arch, commits_i[c].tag);
        end

        for (int l = 0; l < rename_cfg_pkg::LANES; l++) begin
            if (lanes_i[l].valid && lanes_i[l].branch) begin
                n_branch = n_branch + 1'b1;
            end

            // Contiguous from lane 0, needs a ROB tag and a slot per branch
            accept[l] = lanes_i[l].valid && chain_ok
                        && (free_count_i > l)
                        && (n_branch <= free_slots_i)
                        && !restore_i.valid && !flush_i;
            chain_ok  = accept[l];

            // Each lane owns the ROB entry at its tag
            rd_phys = {1'b1, tags_i[l][rename_cfg_pkg::ROB_TAG_W-1:0]};

            // cur already holds earlier lanes, which gives the in-group bypass
            results_o[l].valid       = accept[l];
            results_o[l].rs1_phys    = cur[lanes_i[l].rs1];
            results_o[l].rs2_phys    = cur[lanes_i[l].rs2];
            results_o[l].rd_phys     = rd_phys;
            results_o[l].old_rd_phys = cur[lanes_i[l].rd];

            // x0 and non-writing lanes leave the map alone
            if (accept[l] && lanes_i[l].rd_we && lanes_i[l].rd != '0) begin
                cur[lanes_i[l].rd] = rd_phys;
            end

            // Snapshot after the branch itself, pointer one past its tag
            push_o[l].valid     = accept[l] && lanes_i[l].branch;
            push_o[l].snapshot  = cur;
            push_o[l].alloc_ptr = tags_i[l] + 1'b1;

            if (accept[l]) begin
                n_accept = n_accept + 1'b1;
            end
        end
    end

    assign alloc_count_o = n_accept;

    // ====================
    // Map register
    // ====================

    always_comb begin
        if (flush_i) begin
            map_next = identity_map();
        end else if (restore_i.valid) begin
            // Restore snapshot already has this cycle's commits
            map_next = restore_i.snapshot;
        end else begin
            map_next = cur;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            map_q <= identity_map();
        end else begin
            map_q <= map_next;
        end
    end

endmodule

/* rename/rename_unit.sv */
`timescale 1ns/10ps

module rename_unit (
    input  logic clk,
    input  logic reset,
    input  logic flush_i,
    input  rename_port_pkg::lane_req_t [rename_cfg_pkg::LANES-1:0] lanes_i,
    input  rename_port_pkg::commit_t   [rename_cfg_pkg::LANES-1:0] commits_i,
    input  rename_port_pkg::resolve_t                              resolve_i,
    output rename_port_pkg::lane_res_t [rename_cfg_pkg::LANES-1:0] results_o
);

    // Ring to map
    rename_cfg_pkg::ring_ptr_t [rename_cfg_pkg::LANES-1:0] tags;
    rename_cfg_pkg::rob_count_t                            free_count;

    // Map to ring and stack
    rename_cfg_pkg::lane_cnt_t                             alloc_count;
    rename_port_pkg::restore_t [rename_cfg_pkg::LANES-1:0] push;

    // Stack to map and ring
    rename_port_pkg::restore_t                             restore;
    rename_cfg_pkg::ckpt_count_t                           free_slots;

    // ROB tag allocation
    rob_tag_ring u_ring (
        .clk           (clk),
        .reset         (reset),
        .flush_i       (flush_i),
        .alloc_count_i (alloc_count),
        .commits_i     (commits_i),
        .restore_i     (restore),
        .tags_o        (tags),
        .free_count_o  (free_count)
    );

    // Branch snapshots
    checkpoint_stack u_ckpt (
        .clk          (clk),
        .reset        (reset),
        .flush_i      (flush_i),
        .push_i       (push),
        .commits_i    (commits_i),
        .resolve_i    (resolve_i),
        .restore_o    (restore),
        .free_slots_o (free_slots)
    );

    // Lookup, bypass and map register
    map_table u_map (
        .clk           (clk),
        .reset         (reset),
        .flush_i       (flush_i),
        .lanes_i       (lanes_i),
        .commits_i     (commits_i),
        .tags_i        (tags),
        .free_count_i  (free_count),
        .free_slots_i  (free_slots),
        .restore_i     (restore),
        .results_o     (results_o),
        .alloc_count_o (alloc_count),
        .push_o        (push)
    );

endmodule

/* verif/rename_unit_assert.sv */
`timescale 1ns/10ps

module rename_unit_assert (
    input logic                               clk,
    input logic                               reset,
    input rename_cfg_pkg::phys_reg_t          x0_phys_i,
    input logic [rename_cfg_pkg::LANES-1:0]   accept_i,
    input logic                               restore_valid_i,
    input rename_cfg_pkg::rob_count_t         free_count_i
);

    // Failed assertions so far
    int fail_count = 0;

    // x0 never leaves the register file
    x0_home: assert property (@(posedge clk) disable iff (!reset) x0_phys_i == '0)
        else begin
            $error("x0 maps to physical name %0d", x0_phys_i);
            fail_count++;
        end

    // Accepted lanes form a run from lane 0
    accept_run: assert property (@(posedge clk) disable iff (!reset)
                                 ((accept_i + 1'b1) & accept_i) == '0)
        else begin
            $error("accepted lanes not contiguous: %b", accept_i);
            fail_count++;
        end

    // Restore cycle renames nothing
    restore_block: assert property (@(posedge clk) disable iff (!reset)
                                    restore_valid_i |-> accept_i == '0)
        else begin
            $error("lane accepted during restore: %b", accept_i);
            fail_count++;
        end

    free_limit: assert property (@(posedge clk) disable iff (!reset)
                                 free_count_i <= rename_cfg_pkg::ROB_DEPTH)
        else begin
            $error("free count %0d above ROB depth", free_count_i);
            fail_count++;
        end

endmodule

// Stack restore and ring free count both arrive at the map table
bind map_table rename_unit_assert u_assert (
    .clk             (clk),
    .reset           (reset),
    .x0_phys_i       (map_q[0]),
    .accept_i        (accept),
    .restore_valid_i (restore_i.valid),
    .free_count_i    (free_count_i)
);

/* verif/tb_rename_unit.sv */
`timescale 1ns/10ps

module tb_rename_unit;

    logic clk;
    logic reset;
    logic flush_i;
    rename_port_pkg::lane_req_t [rename_cfg_pkg::LANES-1:0] lanes_i;
    rename_port_pkg::commit_t   [rename_cfg_pkg::LANES-1:0] commits_i;
    rename_port_pkg::resolve_t                              resolve_i;
    rename_port_pkg::lane_res_t [rename_cfg_pkg::LANES-1:0] results_o;

    // One table row, driven for one cycle
    typedef struct packed {
        rename_port_pkg::lane_req_t [rename_cfg_pkg::LANES-1:0] lanes;
        rename_port_pkg::commit_t   [rename_cfg_pkg::LANES-1:0] commits;
        logic                                                   flush;
        rename_port_pkg::resolve_t                              resolve;
    } step_t;

    step_t steps [$];
    int seed = 73269;
    int errors;
    int checks;
    int cycles;
    int cur_step;
    rename_port_pkg::lane_req_t idle  = '0;
    rename_port_pkg::commit_t   no_cm = '0;

    // Reference model state
    rename_cfg_pkg::map_snapshot_t m_map;
    rename_cfg_pkg::ring_ptr_t     m_alloc;
    rename_cfg_pkg::ring_ptr_t     m_rel;
    rename_cfg_pkg::map_snapshot_t ck_snap [$];
    rename_cfg_pkg::ring_ptr_t     ck_ptr [$];

    rename_unit dut0 (
        .clk       (clk),
        .reset     (reset),
        .flush_i   (flush_i),
        .lanes_i   (lanes_i),
        .commits_i (commits_i),
        .resolve_i (resolve_i),
        .results_o (results_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // Stimulus helpers
    // ====================

    function automatic rename_port_pkg::lane_req_t req(logic we, int rs1, int rs2, int rd);
        rename_port_pkg::lane_req_t r;
        r.valid  = 1'b1;
        r.branch = 1'b0;
        r.rd_we  = we;
        r.rs1    = rename_cfg_pkg::arch_reg_t'(rs1);
        r.rs2    = rename_cfg_pkg::arch_reg_t'(rs2);
        r.rd     = rename_cfg_pkg::arch_reg_t'(rd);
        return r;
    endfunction

    // Branch writes no register
    function automatic rename_port_pkg::lane_req_t br(int rs1, int rs2);
        rename_port_pkg::lane_req_t r;
        r        = req(1'b0, rs1, rs2, 0);
        r.branch = 1'b1;
        return r;
    endfunction

    function automatic rename_port_pkg::commit_t cm(int arch, int tag);
        rename_port_pkg::commit_t c;
        c.valid = 1'b1;
        c.arch  = rename_cfg_pkg::arch_reg_t'(arch);
        c.tag   = rename_cfg_pkg::rob_tag_t'(tag);
        return c;
    endfunction

    function automatic int rnd_reg();
        return $random(seed) & 31;
    endfunction

    function automatic rename_port_pkg::lane_req_t rnd_lane();
        return req(1'b1, rnd_reg(), rnd_reg(), rnd_reg());
    endfunction

    // ctl bits: flush, resolve valid, mispredict
    task automatic add_step(
        input rename_port_pkg::lane_req_t l0, l1, l2,
        input rename_port_pkg::commit_t   c0, c1,
        input logic [2:0]                 ctl
    );
        step_t s;
        s.lanes   = {l2, l1, l0};
        s.commits = {no_cm, c1, c0};
        s.flush   = ctl[2];
        s.resolve = ctl[1:0];
        steps.push_back(s);
    endtask

    task automatic build_table();
        // Independent group right after reset
        add_step(req(1, 1, 2, 3), req(1, 4, 5, 6), req(1, 7, 8, 9), no_cm, no_cm, 3'b000);
        // Bypass from lane 0, none from a lane with rd_we low or rd of x0
        add_step(req(1, 3, 0, 10), req(0, 10, rnd_reg(), 12), req(1, 12, 0, 0), no_cm, no_cm, 0);
        add_step(req(1, 12, 13, 0), req(1, 0, 10, 13), req(1, 6, 0, 6), no_cm, no_cm, 0);
        // Tag 0 retires x3, tag 1 is stale for x6
        add_step(req(1, 3, 6, 14), idle, idle, cm(3, 0), cm(6, 1), 0);
        add_step(req(0, 9, 3, 15), idle, idle, cm(9, 2), no_cm, 0);
        // Fill to 30 tags in flight
        for (int k = 0; k < 7; k++) begin
            add_step(rnd_lane(), rnd_lane(), rnd_lane(), no_cm, no_cm, 0);
        end
        add_step(rnd_lane(), idle, idle, no_cm, no_cm, 0);
        // Two free tags, then none
        add_step(rnd_lane(), rnd_lane(), rnd_lane(), no_cm, no_cm, 0);
        add_step(rnd_lane(), rnd_lane(), rnd_lane(), no_cm, no_cm, 0);
        add_step(idle, idle, idle, cm(10, 3), cm(0, 4), 0);
        add_step(idle, idle, idle, cm(0, 5), cm(0, 6), 0);
        add_step(idle, idle, idle, cm(13, 7), cm(6, 8), 0);
        // Three branches, then a fourth fills the stack
        add_step(br(1, 2), br(rnd_reg(), 3), br(4, 5), no_cm, no_cm, 0);
        add_step(req(1, 1, 2, 21), br(21, 3), req(1, 21, 4, 22), cm(14, 9), cm(0, 10), 0);
        // No slot left for the branch in lane 1
        add_step(req(1, 22, 5, 23), br(23, 1), req(1, 1, 1, 24), no_cm, no_cm, 0);
        // Oldest branch correct, next one mispredicted
        add_step(req(1, 23, 21, 20), idle, idle, cm(0, 11), cm(0, 12), 3'b010);
        add_step(req(1, 1, 2, 3), req(1, 4, 5, 6), req(1, 7, 8, 9), cm(0, 13), cm(0, 14), 3'b011);
        add_step(req(1, 20, 21, 25), req(1, 22, 23, 26), req(0, 25, 24, 0), no_cm, no_cm, 0);
        // Flush with retirement in the same cycle
        add_step(req(1, 1, 2, 3), req(1, 4, 5, 6), idle, cm(0, 15), cm(0, 16), 3'b100);
        add_step(req(1, 25, 26, 27), req(1, 27, 20, 28), rnd_lane(), no_cm, no_cm, 0);
        add_step(idle, idle, idle, no_cm, no_cm, 0);
    endtask

    // ====================
    // Reference model
    // ====================

    function automatic rename_cfg_pkg::map_snapshot_t home_map();
        rename_cfg_pkg::map_snapshot_t m;
        for (int r = 0; r < rename_cfg_pkg::ARCH_REGS; r++) begin
            m[r] = rename_cfg_pkg::phys_reg_t'(r);
        end
        return m;
    endfunction

    // ROB entries sit above the register file
    function automatic rename_cfg_pkg::phys_reg_t rob_name(int ptr);
        return rename_cfg_pkg::phys_reg_t'(rename_cfg_pkg::ARCH_REGS
                                           + ptr % rename_cfg_pkg::ROB_DEPTH);
    endfunction

    // A register goes home only if it still names the retiring tag
    function automatic rename_cfg_pkg::map_snapshot_t apply_commits(
        input rename_cfg_pkg::map_snapshot_t                         m,
        input rename_port_pkg::commit_t [rename_cfg_pkg::LANES-1:0] c
    );
        for (int k = 0; k < rename_cfg_pkg::LANES; k++) begin
            if (c[k].valid && c[k].arch != 0 && m[c[k].arch] == rob_name(c[k].tag)) begin
                m[c[k].arch] = rename_cfg_pkg::phys_reg_t'(c[k].arch);
            end
        end
        return m;
    endfunction

    task automatic compare_field(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s step %0d: got 0x%h, expected 0x%h", name, cur_step, got, exp);
        end
    endtask

    task automatic check_step(input step_t s);
        rename_cfg_pkg::map_snapshot_t work;
        rename_cfg_pkg::map_snapshot_t pend_snap [$];
        rename_cfg_pkg::ring_ptr_t     pend_ptr [$];
        int    n_free;
        int    n_branch;
        int    n_acc;
        int    tag;
        logic  chain;
        logic  acc;
        logic  restore;
        string ln;
        restore  = s.resolve.valid && s.resolve.mispredict && ck_snap.size() > 0;
        work     = apply_commits(m_map, s.commits);
        n_free   = rename_cfg_pkg::ROB_DEPTH
                   - int'(rename_cfg_pkg::ring_ptr_t'(m_alloc - m_rel));
        compare_field("free_count", dut0.free_count, n_free);
        chain    = 1'b1;
        n_branch = 0;
        n_acc    = 0;
        for (int l = 0; l < rename_cfg_pkg::LANES; l++) begin
            ln = $sformatf("results_o[%0d]", l);
            if (s.lanes[l].valid && s.lanes[l].branch) begin
                n_branch++;
            end
            acc   = s.lanes[l].valid && chain && n_free > l && !restore && !s.flush
                    && n_branch <= rename_cfg_pkg::CKPT_DEPTH - ck_snap.size();
            chain = acc;
            tag   = int'(m_alloc) + l;
            compare_field({ln, ".valid"}, results_o[l].valid, acc);
            if (acc) begin
                compare_field({ln, ".rs1_phys"}, results_o[l].rs1_phys, work[s.lanes[l].rs1]);
                compare_field({ln, ".rs2_phys"}, results_o[l].rs2_phys, work[s.lanes[l].rs2]);
                compare_field({ln, ".rd_phys"}, results_o[l].rd_phys, rob_name(tag));
                compare_field({ln, ".old_rd_phys"}, results_o[l].old_rd_phys,
                              work[s.lanes[l].rd]);
                // Later lanes see this write
                if (s.lanes[l].rd_we && s.lanes[l].rd != 0) begin
                    work[s.lanes[l].rd] = rob_name(tag);
                end
                if (s.lanes[l].branch) begin
                    pend_snap.push_back(work);
                    pend_ptr.push_back(rename_cfg_pkg::ring_ptr_t'(tag + 1));
                end
                n_acc++;
            end
        end
        // State after the edge
        for (int c = 0; c < rename_cfg_pkg::LANES; c++) begin
            if (s.commits[c].valid) begin
                m_rel++;
            end
        end
        if (s.flush) begin
            m_map   = home_map();
            m_alloc = m_rel;
            ck_snap.delete();
            ck_ptr.delete();
        end else if (restore) begin
            m_map   = apply_commits(ck_snap[0], s.commits);
            m_alloc = ck_ptr[0];
            ck_snap.delete();
            ck_ptr.delete();
        end else begin
            m_map   = work;
            m_alloc = m_alloc + rename_cfg_pkg::ring_ptr_t'(n_acc);
            foreach (ck_snap[i]) begin
                ck_snap[i] = apply_commits(ck_snap[i], s.commits);
            end
            // Correct branch drops the oldest checkpoint
            if (s.resolve.valid && ck_snap.size() > 0) begin
                void'(ck_snap.pop_front());
                void'(ck_ptr.pop_front());
            end
            foreach (pend_snap[i]) begin
                ck_snap.push_back(pend_snap[i]);
                ck_ptr.push_back(pend_ptr[i]);
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        reset     = 1'b0;
        flush_i   = 1'b0;
        lanes_i   = '0;
        commits_i = '0;
        resolve_i = '0;
        errors    = 0;
        checks    = 0;
        cur_step  = 0;
        m_map     = home_map();
        m_alloc   = '0;
        m_rel     = '0;
        build_table();
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        foreach (steps[i]) begin
            @(posedge clk);
            cur_step = i;
            lanes_i   <= steps[i].lanes;
            commits_i <= steps[i].commits;
            resolve_i <= steps[i].resolve;
            flush_i   <= steps[i].flush;
            // Results are combinational, stable by mid cycle
            @(negedge clk);
            check_step(steps[i]);
        end
        // Bound assertion failures count as errors too
        errors = errors + dut0.u_map.u_assert.fail_count;
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog on table length
    initial begin
        cycles = 0;
        while (cycles <= steps.size() + 20) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the stimulus table did not complete", cycles);
        $display("Regression failed");
        $finish;
    end

endmodule
